// File: riscv_core_top.f
+incdir+tb
verilog/core_pkg.sv
verilog/rv_isa_pkg.sv
verilog/mem_bus_if.sv
verilog/pc_counter.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/unified_mem.sv
verilog/core_ctrl.sv
verilog/riscv_core_top.sv
tb/tb_riscv_core_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f riscv_core_top.f --top-module tb_riscv_core_top \
    -o sim_riscv_core_top > build.log 2>&1 \
    && ./obj_dir/sim_riscv_core_top > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

// File: tb/rv_asm.svh
// RV32I instruction encoders
`ifndef RV_ASM_SVH
`define RV_ASM_SVH

// funct3 of LW and SW
localparam rv_isa_pkg::funct3_t F3_WORD = 3'b010;

function automatic core_pkg::instr_t enc_r(rv_isa_pkg::funct10_t f10, core_pkg::reg_sel_t rd,
        core_pkg::reg_sel_t rs1, core_pkg::reg_sel_t rs2);
    return {f10[9:3], rs2, rs1, f10[2:0], rd, rv_isa_pkg::OP_OP};
endfunction

function automatic core_pkg::instr_t enc_i(rv_isa_pkg::opcode_t op, rv_isa_pkg::funct3_t f3,
        core_pkg::reg_sel_t rd, core_pkg::reg_sel_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic core_pkg::instr_t enc_addi(core_pkg::reg_sel_t rd, core_pkg::reg_sel_t rs1,
        logic [11:0] imm);
    return enc_i(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADDI, rd, rs1, imm);
endfunction

function automatic core_pkg::instr_t enc_lw(core_pkg::reg_sel_t rd, core_pkg::reg_sel_t rs1,
        logic [11:0] imm);
    return enc_i(rv_isa_pkg::OP_LOAD, F3_WORD, rd, rs1, imm);
endfunction

function automatic core_pkg::instr_t enc_sw(core_pkg::reg_sel_t rs2, core_pkg::reg_sel_t rs1,
        logic [11:0] imm);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], rv_isa_pkg::OP_STORE};
endfunction

// off is the signed byte distance from the branch itself
function automatic core_pkg::instr_t enc_branch(rv_isa_pkg::funct3_t f3,
        core_pkg::reg_sel_t rs1, core_pkg::reg_sel_t rs2, logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OP_BRANCH};
endfunction

function automatic core_pkg::instr_t enc_beq(core_pkg::reg_sel_t rs1, core_pkg::reg_sel_t rs2,
        logic [12:0] off);
    return enc_branch(rv_isa_pkg::F3_BEQ, rs1, rs2, off);
endfunction

function automatic core_pkg::instr_t enc_bne(core_pkg::reg_sel_t rs1, core_pkg::reg_sel_t rs2,
        logic [12:0] off);
    return enc_branch(rv_isa_pkg::F3_BNE, rs1, rs2, off);
endfunction

function automatic core_pkg::instr_t enc_lui(core_pkg::reg_sel_t rd, logic [19:0] upper);
    return {upper, rd, rv_isa_pkg::OP_LUI};
endfunction

function automatic core_pkg::instr_t enc_auipc(core_pkg::reg_sel_t rd, logic [19:0] upper);
    return {upper, rd, rv_isa_pkg::OP_AUIPC};
endfunction

// stores relative to x0 that hit the mapped ports
function automatic core_pkg::instr_t enc_out(core_pkg::reg_sel_t rs);
    return enc_sw(rs, 5'd0, 12'(core_pkg::OUT_INT_ADDR));
endfunction

function automatic core_pkg::instr_t enc_out_float(core_pkg::reg_sel_t rs);
    return enc_sw(rs, 5'd0, 12'(core_pkg::OUT_FLOAT_ADDR));
endfunction

function automatic core_pkg::instr_t enc_halt();
    return enc_sw(5'd0, 5'd0, 12'(core_pkg::HALT_ADDR));
endfunction

`endif

// File: tb/tb_riscv_core_top.sv
// RV32I core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core_top;

    `include "rv_asm.svh"

    localparam int          CLK_HALF         = 4;
    localparam int          RESET_CYCLES     = 16;
    localparam int          CYCLES_PER_INSTR = 200;
    localparam logic [31:0] LFSR_SEED        = 32'd93419;
    // data area, clear of the program and the mapped ports
    localparam logic [11:0] DATA_BASE        = 12'h600;

    localparam rv_isa_pkg::funct10_t OP_LIST [11] = '{
        rv_isa_pkg::F10_ADD, rv_isa_pkg::F10_SUB, rv_isa_pkg::F10_AND, rv_isa_pkg::F10_OR,
        rv_isa_pkg::F10_XOR, rv_isa_pkg::F10_SLL, rv_isa_pkg::F10_SRL, rv_isa_pkg::F10_SRA,
        rv_isa_pkg::F10_SLT, rv_isa_pkg::F10_SLTU, rv_isa_pkg::F10_MUL
    };

    logic            clk;
    logic            rst;
    logic            prog_we;
    core_pkg::addr_t prog_addr;
    core_pkg::data_t prog_data;
    core_pkg::data_t out_data;
    logic            out_valid;
    logic            out_float_valid;
    logic            halt;

    core_pkg::instr_t prog[$];
    core_pkg::data_t  exp_q[$];
    core_pkg::data_t  int_q[$];
    core_pkg::data_t  float_q[$];
    logic [31:0]      lfsr = LFSR_SEED;
    int               errors = 0;
    int               checks = 0;
    int               cycle_budget = 0;

    riscv_core_top dut_i (
        .clk, .rst, .prog_we, .prog_addr, .prog_data,
        .out_data, .out_valid, .out_float_valid, .halt
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // reference results of the OP group
    function automatic core_pkg::data_t alu_model(rv_isa_pkg::funct10_t f10,
            core_pkg::data_t a, core_pkg::data_t b);
        logic [4:0]  sh;
        logic [63:0] prod;
        sh   = b[4:0];
        prod = {32'b0, a} * {32'b0, b};
        case (f10)
            rv_isa_pkg::F10_ADD:  return a + b;
            rv_isa_pkg::F10_SUB:  return a - b;
            rv_isa_pkg::F10_AND:  return a & b;
            rv_isa_pkg::F10_OR:   return a | b;
            rv_isa_pkg::F10_XOR:  return a ^ b;
            rv_isa_pkg::F10_SLL:  return a << sh;
            rv_isa_pkg::F10_SRL:  return a >> sh;
            rv_isa_pkg::F10_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            // differing signs decide by the sign of a
            rv_isa_pkg::F10_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            rv_isa_pkg::F10_SLTU: return {31'b0, a < b};
            rv_isa_pkg::F10_MUL:  return prod[31:0];
            default:              return '0;
        endcase
    endfunction

    function automatic void emit(core_pkg::instr_t w);
        prog.push_back(w);
    endfunction

    // LUI plus ADDI, upper part rounded for the sign of the low twelve bits
    function automatic void emit_const(core_pkg::reg_sel_t rd, core_pkg::data_t v);
        core_pkg::data_t hi;
        hi = v + 32'h800;
        emit(enc_lui(rd, hi[31:12]));
        emit(enc_addi(rd, rd, v[11:0]));
    endfunction

    task automatic check_data(core_pkg::data_t got, core_pkg::data_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // program goes in while the core sits in reset
    task automatic load_program();
        cycle_budget += CYCLES_PER_INSTR * prog.size();
        @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= core_pkg::addr_t'(4 * i);
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        for (int i = prog.size() + 1; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        int_q.delete();
        float_q.delete();
        rst <= 1'b0;
    endtask

    task automatic run_program();
        load_program();
        while (halt !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic compare_outputs(string what);
        if (int_q.size() != exp_q.size()) begin
            errors++;
            $display("%s test gave %0d outputs where %0d were expected",
                     what, int_q.size(), exp_q.size());
        end
        for (int i = 0; i < int_q.size() && i < exp_q.size(); i++) begin
            check_data(int_q[i], exp_q[i], $sformatf("%s output %0d", what, i));
        end
    endtask

    // halt has to stay up on every cycle after it rose
    task automatic expect_halt_held(string what);
        repeat (20) begin
            @(negedge clk);
            check_flag(halt, 1'b1, $sformatf("%s halt", what));
        end
    endtask

    task automatic alu_operations();
        core_pkg::data_t a;
        core_pkg::data_t b;
        logic [11:0]     imm;
        prog.delete();
        exp_q.delete();
        for (int round = 0; round < 2; round++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            // negative a against positive b separates SLT from SLTU
            if (round == 1) begin
                a[31] = 1'b1;
                b[31] = 1'b0;
            end
            emit_const(5'd1, a);
            emit_const(5'd2, b);
            for (int k = 0; k < 11; k++) begin
                emit(enc_r(OP_LIST[k], 5'd3, 5'd1, 5'd2));
                emit(enc_out(5'd3));
                exp_q.push_back(alu_model(OP_LIST[k], a, b));
            end
            imm = 12'(rand_bits(12));
            emit(enc_addi(5'd4, 5'd1, imm));
            emit(enc_out(5'd4));
            exp_q.push_back(a + {{20{imm[11]}}, imm});
        end
        emit(enc_halt());
        run_program();
        compare_outputs("alu");
    endtask

    task automatic load_store_order();
        core_pkg::data_t w [4];
        int              order [4];
        prog.delete();
        exp_q.delete();
        order = '{3, 1, 0, 2};
        emit(enc_addi(5'd5, 5'd0, DATA_BASE));
        for (int k = 0; k < 4; k++) begin
            w[k] = rand_bits(32);
            emit_const(5'(6 + k), w[k]);
            emit(enc_sw(5'(6 + k), 5'd5, 12'(8 * k)));
        end
        for (int j = 0; j < 4; j++) begin
            emit(enc_lw(5'(10 + j), 5'd5, 12'(8 * order[j])));
            emit(enc_out(5'(10 + j)));
            exp_q.push_back(w[order[j]]);
        end
        // x0 as the target of a load and of an ADDI
        emit(enc_lw(5'd0, 5'd5, 12'd0));
        emit(enc_out(5'd0));
        exp_q.push_back('0);
        emit(enc_addi(5'd0, 5'd0, 12'd5));
        emit(enc_out(5'd0));
        exp_q.push_back('0);
        emit(enc_halt());
        run_program();
        compare_outputs("load/store");
    endtask

    task automatic branch_countdown();
        int          n;
        logic [11:0] marker;
        prog.delete();
        exp_q.delete();
        n      = 3 + int'(rand_bits(2));
        marker = 12'd77;
        emit(enc_addi(5'd1, 5'd0, 12'(n)));
        // loop body starts at byte 4
        emit(enc_out(5'd1));
        emit(enc_addi(5'd1, 5'd1, 12'hfff));
        emit(enc_bne(5'd1, 5'd0, -13'sd8));
        // taken, lands on the marker at byte 28
        emit(enc_beq(5'd0, 5'd0, 13'sd12));
        emit(enc_addi(5'd3, 5'd0, 12'd111));
        emit(enc_out(5'd3));
        emit(enc_addi(5'd4, 5'd0, marker));
        // not taken
        emit(enc_beq(5'd4, 5'd0, 13'sd8));
        emit(enc_out(5'd4));
        emit(enc_halt());
        for (int i = n; i > 0; i--) begin
            exp_q.push_back(core_pkg::data_t'(i));
        end
        exp_q.push_back({20'b0, marker});
        run_program();
        compare_outputs("branch");
    endtask

    task automatic upper_immediates();
        logic [19:0] u;
        prog.delete();
        exp_q.delete();
        u = 20'(rand_bits(20));
        emit(enc_lui(5'd1, u));
        emit(enc_out(5'd1));
        exp_q.push_back({u, 12'b0});
        for (int k = 0; k < 2; k++) begin
            u = 20'(rand_bits(20));
            // pc of the AUIPC is its slot in the program
            exp_q.push_back({u, 12'b0} + core_pkg::data_t'(4 * prog.size()));
            emit(enc_auipc(5'(2 + k), u));
            emit(enc_out(5'(2 + k)));
        end
        emit(enc_halt());
        run_program();
        compare_outputs("lui/auipc");
    endtask

    task automatic float_port_and_halt();
        core_pkg::data_t v;
        prog.delete();
        exp_q.delete();
        v = rand_bits(32);
        emit_const(5'd1, v);
        emit(enc_out_float(5'd1));
        emit(enc_halt());
        emit(enc_out(5'd1));
        emit(enc_halt());
        run_program();
        expect_halt_held("float/halt");
        compare_outputs("float/halt");
        if (float_q.size() != 1) begin
            errors++;
            $display("float port gave %0d outputs where 1 was expected", float_q.size());
        end else begin
            check_data(float_q[0], v, "float output");
        end

        // second program stops on an opcode the core does not know
        prog.delete();
        exp_q.delete();
        v = rand_bits(32);
        emit_const(5'd1, v);
        emit(enc_out(5'd1));
        emit(32'h0000_007f);
        emit(enc_out(5'd1));
        emit(enc_halt());
        exp_q.push_back(v);
        run_program();
        expect_halt_held("unknown opcode");
        compare_outputs("unknown opcode");
    endtask

    // outputs are stable away from the rising edge
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            int_q.push_back(out_data);
        end
        if (out_float_valid === 1'b1) begin
            float_q.push_back(out_data);
        end
        if (out_valid === 1'b1 && out_float_valid === 1'b1) begin
            errors++;
            $display("both output strobes were high together at %0d ns", $time);
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles <= cycle_budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the core did not halt within %0d cycles", cycle_budget);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        alu_operations();
        load_store_order();
        branch_countdown();
        upper_immediates();
        float_port_and_halt();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
// Integer ALU
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire rv_isa_pkg::alu_op_t op,
    input  wire core_pkg::data_t     a,
    input  wire core_pkg::data_t     b,
    output core_pkg::data_t          result,
    output logic                     zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_isa_pkg::ALU_ADD:  result = a + b;
            rv_isa_pkg::ALU_SUB:  result = a - b;
            rv_isa_pkg::ALU_AND:  result = a & b;
            rv_isa_pkg::ALU_OR:   result = a | b;
            rv_isa_pkg::ALU_XOR:  result = a ^ b;
            rv_isa_pkg::ALU_SLL:  result = a << shamt;
            rv_isa_pkg::ALU_SRL:  result = a >> shamt;
            // sign bit fills from the left
            rv_isa_pkg::ALU_SRA:  result = core_pkg::data_t'($signed(a) >>> shamt);
            rv_isa_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            rv_isa_pkg::ALU_SLTU: result = {31'b0, a < b};
            // low word of the product
            rv_isa_pkg::ALU_MUL:  result = a * b;
            default:              result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: verilog/core_ctrl.sv
// Core control FSM
`timescale 1ns/1ps
`default_nettype none

module core_ctrl (
    input  wire logic                clk,
    input  wire logic                rst,
    mem_bus_if.core                  mem,
    output core_pkg::reg_sel_t       rs1_sel,
    output core_pkg::reg_sel_t       rs2_sel,
    input  wire core_pkg::data_t     rs1_data,
    input  wire core_pkg::data_t     rs2_data,
    output logic                     wr_en,
    output core_pkg::reg_sel_t       wr_sel,
    output core_pkg::data_t          wr_data,
    output rv_isa_pkg::alu_op_t      alu_op,
    output core_pkg::data_t          alu_a,
    output core_pkg::data_t          alu_b,
    input  wire core_pkg::data_t     alu_result,
    input  wire logic                alu_zero,
    output logic                     pc_step,
    output logic                     pc_jump,
    output core_pkg::addr_t          pc_offset,
    input  wire core_pkg::addr_t     pc,
    input  wire core_pkg::addr_t     next_pc,
    output core_pkg::data_t          out_data,
    output logic                     out_valid,
    output logic                     out_float_valid,
    output logic                     halt
);

    core_pkg::state_t     state;
    core_pkg::state_t     state_nx;
    // pending access in MEM_WAIT is a load, otherwise a store
    logic                 pend_load;
    core_pkg::reg_sel_t   load_rd;
    logic                 issue_mem;
    logic                 fetch_next;

    core_pkg::instr_t     instr;
    rv_isa_pkg::opcode_t  opcode;
    rv_isa_pkg::funct3_t  funct3;
    rv_isa_pkg::funct10_t funct10;
    core_pkg::reg_sel_t   rd;
    core_pkg::data_t      imm_i;
    core_pkg::data_t      imm_s;
    core_pkg::data_t      imm_u;

    // instruction word is valid in the ack cycle of EXECUTE
    assign instr   = mem.rd_data;
    assign opcode  = instr[6:0];
    assign rd      = instr[11:7];
    assign funct3  = instr[14:12];
    assign funct10 = {instr[31:25], instr[14:12]};
    assign rs1_sel = instr[19:15];
    assign rs2_sel = instr[24:20];

    assign imm_i     = {{20{instr[31]}}, instr[31:20]};
    assign imm_s     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u     = {instr[31:12], 12'b0};
    assign pc_offset = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    assign out_data = rs2_data;
    assign halt     = (state == core_pkg::HALTED);

    always_comb begin
        state_nx        = state;
        issue_mem       = 1'b0;
        fetch_next      = 1'b0;
        mem.addr        = next_pc;
        mem.wr_data     = rs2_data;
        mem.rd_req      = 1'b0;
        mem.wr_req      = 1'b0;
        wr_en           = 1'b0;
        wr_sel          = rd;
        wr_data         = alu_result;
        alu_op          = rv_isa_pkg::ALU_ADD;
        alu_a           = rs1_data;
        alu_b           = rs2_data;
        pc_jump         = 1'b0;
        out_valid       = 1'b0;
        out_float_valid = 1'b0;

        case (state)
            core_pkg::FETCH: begin
                mem.addr   = pc;
                mem.rd_req = 1'b1;
                state_nx   = core_pkg::EXECUTE;
            end
            core_pkg::EXECUTE: if (mem.ack) begin
                case (opcode)
                    rv_isa_pkg::OP_IMM: begin
                        alu_b      = imm_i;
                        wr_en      = (funct3 == rv_isa_pkg::F3_ADDI);
                        fetch_next = wr_en;
                        if (!wr_en) begin
                            state_nx = core_pkg::HALTED;
                        end
                    end
                    rv_isa_pkg::OP_OP: begin
                        wr_en      = 1'b1;
                        fetch_next = 1'b1;
                        case (funct10)
                            rv_isa_pkg::F10_ADD:  alu_op = rv_isa_pkg::ALU_ADD;
                            rv_isa_pkg::F10_SUB:  alu_op = rv_isa_pkg::ALU_SUB;
                            rv_isa_pkg::F10_AND:  alu_op = rv_isa_pkg::ALU_AND;
                            rv_isa_pkg::F10_OR:   alu_op = rv_isa_pkg::ALU_OR;
                            rv_isa_pkg::F10_XOR:  alu_op = rv_isa_pkg::ALU_XOR;
                            rv_isa_pkg::F10_SLL:  alu_op = rv_isa_pkg::ALU_SLL;
                            rv_isa_pkg::F10_SRL:  alu_op = rv_isa_pkg::ALU_SRL;
                            rv_isa_pkg::F10_SRA:  alu_op = rv_isa_pkg::ALU_SRA;
                            rv_isa_pkg::F10_SLT:  alu_op = rv_isa_pkg::ALU_SLT;
                            rv_isa_pkg::F10_SLTU: alu_op = rv_isa_pkg::ALU_SLTU;
                            rv_isa_pkg::F10_MUL:  alu_op = rv_isa_pkg::ALU_MUL;
                            default: begin
                                wr_en      = 1'b0;
                                fetch_next = 1'b0;
                                state_nx   = core_pkg::HALTED;
                            end
                        endcase
                    end
                    rv_isa_pkg::OP_LUI: begin
                        wr_data    = imm_u;
                        wr_en      = 1'b1;
                        fetch_next = 1'b1;
                    end
                    rv_isa_pkg::OP_AUIPC: begin
                        alu_a      = pc;
                        alu_b      = imm_u;
                        wr_en      = 1'b1;
                        fetch_next = 1'b1;
                    end
                    rv_isa_pkg::OP_BRANCH: begin
                        // rs1 - rs2 gives equality through the zero flag
                        alu_op = rv_isa_pkg::ALU_SUB;
                        if (funct3 == rv_isa_pkg::F3_BEQ) begin
                            pc_jump    = alu_zero;
                            fetch_next = 1'b1;
                        end else if (funct3 == rv_isa_pkg::F3_BNE) begin
                            pc_jump    = !alu_zero;
                            fetch_next = 1'b1;
                        end else begin
                            state_nx = core_pkg::HALTED;
                        end
                    end
                    rv_isa_pkg::OP_LOAD: begin
                        alu_b      = imm_i;
                        mem.addr   = alu_result;
                        mem.rd_req = 1'b1;
                        issue_mem  = 1'b1;
                        state_nx   = core_pkg::MEM_WAIT;
                    end
                    rv_isa_pkg::OP_STORE: begin
                        alu_b = imm_s;
                        case (alu_result)
                            core_pkg::OUT_INT_ADDR: begin
                                out_valid  = 1'b1;
                                fetch_next = 1'b1;
                            end
                            core_pkg::OUT_FLOAT_ADDR: begin
                                out_float_valid = 1'b1;
                                fetch_next      = 1'b1;
                            end
                            core_pkg::HALT_ADDR: state_nx = core_pkg::HALTED;
                            default: begin
                                mem.addr   = alu_result;
                                mem.wr_req = 1'b1;
                                issue_mem  = 1'b1;
                                state_nx   = core_pkg::MEM_WAIT;
                            end
                        endcase
                    end
                    default: state_nx = core_pkg::HALTED;
                endcase
            end
            core_pkg::MEM_WAIT: if (mem.ack) begin
                wr_en      = pend_load;
                wr_sel     = load_rd;
                wr_data    = mem.rd_data;
                fetch_next = 1'b1;
                state_nx   = core_pkg::EXECUTE;
            end
            default: begin
            end
        endcase

        // next fetch goes out at next_pc in the same cycle
        if (fetch_next) begin
            mem.rd_req = 1'b1;
        end
        pc_step = fetch_next && !pc_jump;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= core_pkg::FETCH;
            pend_load <= 1'b0;
        end else begin
            state <= state_nx;
            if (issue_mem) begin
                pend_load <= (opcode == rv_isa_pkg::OP_LOAD);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_mem) begin
            load_rd <= rd;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(state));

    a_no_rd_wr: assert property (@(posedge clk) disable iff (rst)
        !(mem.rd_req && mem.wr_req));

endmodule

`default_nettype wire

// File: verilog/core_pkg.sv
// Core widths and memory map
`default_nettype none

package core_pkg;

    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_sel_t;

    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        MEM_WAIT,
        HALTED
    } state_t;

    // unified memory, in 32-bit words
    localparam int MEM_WORDS = 1024;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    // store addresses that never reach memory
    localparam addr_t OUT_INT_ADDR   = 32'd1000;
    localparam addr_t HALT_ADDR      = 32'd1004;
    localparam addr_t OUT_FLOAT_ADDR = 32'd1008;

endpackage

`default_nettype wire

// File: verilog/mem_bus_if.sv
// Memory bus
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;

    core_pkg::addr_t addr;
    core_pkg::data_t wr_data;
    core_pkg::data_t rd_data;
    logic            wr_req;
    logic            rd_req;
    // one cycle after any request
    logic            ack;

    modport core (
        output addr, wr_data, wr_req, rd_req,
        input  rd_data, ack
    );

    modport mem (
        input  addr, wr_data, wr_req, rd_req,
        output rd_data, ack
    );

endinterface

`default_nettype wire

// File: verilog/pc_counter.sv
// Program counter
`timescale 1ns/1ps
`default_nettype none

module pc_counter (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            step,
    input  wire logic            jump,
    input  wire core_pkg::addr_t offset,
    output core_pkg::addr_t      pc,
    output core_pkg::addr_t      next_pc
);

    // a taken branch wins over the sequential step
    always_comb begin
        if (jump) begin
            next_pc = pc + offset;
        end else if (step) begin
            next_pc = pc + 32'd4;
        end else begin
            next_pc = pc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire core_pkg::reg_sel_t rs1_sel,
    input  wire core_pkg::reg_sel_t rs2_sel,
    output core_pkg::data_t         rs1_data,
    output core_pkg::data_t         rs2_data,
    input  wire logic               wr_en,
    input  wire core_pkg::reg_sel_t wr_sel,
    input  wire core_pkg::data_t    wr_data
);

    core_pkg::data_t regs [32];

    assign rs1_data = regs[rs1_sel];
    assign rs2_data = regs[rs2_sel];

    // x0 is only ever written by reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_sel != '0) begin
            regs[wr_sel] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/riscv_core_top.sv
// RV32I core top level
`timescale 1ns/1ps
`default_nettype none

module riscv_core_top (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            prog_we,
    input  wire core_pkg::addr_t prog_addr,
    input  wire core_pkg::data_t prog_data,
    output core_pkg::data_t      out_data,
    output logic                 out_valid,
    output logic                 out_float_valid,
    output logic                 halt
);

    core_pkg::reg_sel_t  rs1_sel;
    core_pkg::reg_sel_t  rs2_sel;
    core_pkg::data_t     rs1_data;
    core_pkg::data_t     rs2_data;
    logic                wr_en;
    core_pkg::reg_sel_t  wr_sel;
    core_pkg::data_t     wr_data;
    rv_isa_pkg::alu_op_t alu_op;
    core_pkg::data_t     alu_a;
    core_pkg::data_t     alu_b;
    core_pkg::data_t     alu_result;
    logic                alu_zero;
    logic                pc_step;
    logic                pc_jump;
    core_pkg::addr_t     pc_offset;
    core_pkg::addr_t     pc;
    core_pkg::addr_t     next_pc;

    mem_bus_if mem_bus ();

    core_ctrl ctrl_i (
        .clk, .rst, .mem(mem_bus.core),
        .rs1_sel, .rs2_sel, .rs1_data, .rs2_data,
        .wr_en, .wr_sel, .wr_data,
        .alu_op, .alu_a, .alu_b, .alu_result, .alu_zero,
        .pc_step, .pc_jump, .pc_offset, .pc, .next_pc,
        .out_data, .out_valid, .out_float_valid, .halt
    );

    pc_counter pc_i (
        .clk, .rst, .step(pc_step), .jump(pc_jump), .offset(pc_offset), .pc, .next_pc
    );

    reg_file rf_i (
        .clk, .rst, .rs1_sel, .rs2_sel, .rs1_data, .rs2_data, .wr_en, .wr_sel, .wr_data
    );

    alu alu_i (
        .op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .zero(alu_zero)
    );

    unified_mem mem_i (
        .clk, .rst, .bus(mem_bus.mem), .prog_we, .prog_addr, .prog_data
    );

endmodule

`default_nettype wire

// File: verilog/rv_isa_pkg.sv
// RV32I instruction encodings
`default_nettype none

package rv_isa_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    // funct7 joined with funct3
    typedef logic [9:0] funct10_t;

    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_OP     = 7'b0110011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

    localparam funct3_t F3_ADDI = 3'b000;
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;

    localparam funct10_t F10_ADD  = {7'b0000000, 3'b000};
    localparam funct10_t F10_SUB  = {7'b0100000, 3'b000};
    localparam funct10_t F10_SLL  = {7'b0000000, 3'b001};
    localparam funct10_t F10_SLT  = {7'b0000000, 3'b010};
    localparam funct10_t F10_SLTU = {7'b0000000, 3'b011};
    localparam funct10_t F10_XOR  = {7'b0000000, 3'b100};
    localparam funct10_t F10_SRL  = {7'b0000000, 3'b101};
    localparam funct10_t F10_SRA  = {7'b0100000, 3'b101};
    localparam funct10_t F10_OR   = {7'b0000000, 3'b110};
    localparam funct10_t F10_AND  = {7'b0000000, 3'b111};
    // RV32M
    localparam funct10_t F10_MUL  = {7'b0000001, 3'b000};

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_MUL
    } alu_op_t;

endpackage

`default_nettype wire

// File: verilog/unified_mem.sv
// Unified word memory
`timescale 1ns/1ps
`default_nettype none

module unified_mem (
    input  wire logic            clk,
    input  wire logic            rst,
    mem_bus_if.mem               bus,
    input  wire logic            prog_we,
    input  wire core_pkg::addr_t prog_addr,
    input  wire core_pkg::data_t prog_data
);

    core_pkg::data_t ram [core_pkg::MEM_WORDS];

    logic [core_pkg::MEM_IDX_W-1:0] bus_idx;
    logic [core_pkg::MEM_IDX_W-1:0] prog_idx;

    // byte address to word index
    assign bus_idx  = bus.addr[core_pkg::MEM_IDX_W+1:2];
    assign prog_idx = prog_addr[core_pkg::MEM_IDX_W+1:2];

    // program load runs while the core sits in reset
    always_ff @(posedge clk) begin
        if (prog_we) begin
            ram[prog_idx] <= prog_data;
        end else if (bus.wr_req) begin
            ram[bus_idx] <= bus.wr_data;
        end
        if (bus.rd_req) begin
            bus.rd_data <= ram[bus_idx];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.rd_req || bus.wr_req;
        end
    end

    a_addr_range: assert property (@(posedge clk) disable iff (rst)
        (bus.rd_req || bus.wr_req) |-> bus.addr < core_pkg::addr_t'(core_pkg::MEM_WORDS * 4));

endmodule

`default_nettype wire
